/* Bender.yml */
package:
  name: periph_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/periph_pkg.sv
      - rtl/apb_splitter.sv
      - rtl/gpio.sv
      - rtl/pwm_tiny.sv
      - rtl/tbman.sv
      - rtl/periph_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_periph_core.sv

/* build.f */
+incdir+rtl
rtl/periph_pkg.sv
rtl/apb_splitter.sv
rtl/gpio.sv
rtl/pwm_tiny.sv
rtl/tbman.sv
rtl/periph_core.sv
test/tb_periph_core.sv

/* rtl/apb_splitter.sv */
// ==================================================
// APB address splitter for three slots.
// Slaves must answer with zero wait states, so
// pready is tied high. Unmapped slots read zero
// and raise pslverr in the access phase.
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "periph_settings.svh"

module apb_splitter import periph_pkg::*; (
	input  logic   clk_sys,
	input  logic   rst,

	input  logic   psel,
	input  logic   penable,
	input  paddr_t paddr,

	output logic   psel_gpio,
	output logic   psel_pwm,
	output logic   psel_tbman,

	input  pdata_t prdata_gpio,
	input  pdata_t prdata_pwm,
	input  pdata_t prdata_tbman,

	output pdata_t prdata,
	output logic   pready,
	output logic   pslverr
);

apb_phase_e phase;      // Phase the bus was in on the previous cycle
logic [3:0] slot;
logic       hit_gpio;
logic       hit_pwm;
logic       hit_tbman;
logic       access;

// ==================================================
// Phase tracking
// ==================================================

always_ff @(posedge clk_sys) begin
	if (rst) begin
		phase <= IDLE;
	end else if (!psel) begin
		phase <= IDLE;
	end else if (!penable) begin
		phase <= SETUP;
	end else begin
		phase <= ACCESS;
	end
end

// A legal access phase always follows a setup cycle
assign access = psel && penable && phase == SETUP;

// ==================================================
// Slot decode and read data return
// ==================================================

assign slot      = paddr[`W_PADDR-1 -: 4];
assign hit_gpio  = slot == `SLOT_GPIO;
assign hit_pwm   = slot == `SLOT_PWM;
assign hit_tbman = slot == `SLOT_TBMAN;

assign psel_gpio  = psel && hit_gpio;
assign psel_pwm   = psel && hit_pwm;
assign psel_tbman = psel && hit_tbman;

always_comb begin
	case (slot)
		`SLOT_GPIO:  prdata = prdata_gpio;
		`SLOT_PWM:   prdata = prdata_pwm;
		`SLOT_TBMAN: prdata = prdata_tbman;
		default:     prdata = '0;  // Nothing lives here
	endcase
end

assign pready  = 1'b1;
assign pslverr = access && !(hit_gpio || hit_pwm || hit_tbman);

// Master side protocol
a_enable_after_setup: assert property (@(posedge clk_sys) disable iff (rst)
	psel && penable |-> phase == SETUP);

a_addr_stable: assert property (@(posedge clk_sys) disable iff (rst)
	psel && penable |-> $stable(paddr));

endmodule

`default_nettype wire

/* rtl/gpio.sv */
// ==================================================
// GPIO block. OUT at 0x0 and OE at 0x4 are R/W,
// IN at 0x8 is read-only and shows pads as they
// stood two cycles earlier.
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "periph_settings.svh"

module gpio import periph_pkg::*; (
	input  logic   clk_sys,
	input  logic   rst,

	input  logic   psel,
	input  logic   penable,
	input  logic   pwrite,
	input  paddr_t paddr,
	input  pdata_t pwdata,
	output pdata_t prdata,

	input  pad_t   padin,
	output pad_t   padout,
	output pad_t   padoe
);

pad_t       out_q;
pad_t       oe_q;
pad_t       in_meta;   // First synchronizer stage
pad_t       in_q;      // Second stage, seen through IN
logic [3:0] offset;
logic       wen;

assign offset = {paddr[3:2], 2'b00};
assign wen    = psel && penable && pwrite;

always_ff @(posedge clk_sys) begin
	if (rst) begin
		out_q <= '0;
		oe_q  <= '0;
	end else if (wen) begin
		if (offset == `REG_0)
			out_q <= pwdata[`N_PADS-1:0];
		if (offset == `REG_4)
			oe_q <= pwdata[`N_PADS-1:0];
	end
end

// Two-flop synchronizer on the pad inputs
always_ff @(posedge clk_sys) begin
	if (rst) begin
		in_meta <= '0;
		in_q    <= '0;
	end else begin
		in_meta <= padin;
		in_q    <= in_meta;
	end
end

always_comb begin
	case (offset)
		`REG_0:  prdata = pdata_t'(out_q);
		`REG_4:  prdata = pdata_t'(oe_q);
		`REG_8:  prdata = pdata_t'(in_q);
		default: prdata = '0;
	endcase
end

assign padout = out_q;
assign padoe  = oe_q;

a_in_readonly: assert property (@(posedge clk_sys) disable iff (rst)
	wen && offset == `REG_8 |=> $stable(out_q) && $stable(oe_q));

endmodule

`default_nettype wire

/* rtl/periph_core.sv */
// ==================================================
// Peripheral segment top. The APB master sits
// outside and must follow setup then access. All
// slaves are zero wait state.
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module periph_core import periph_pkg::*; (
	input  logic   clk_sys,
	input  logic   rst,

	// APB slave port
	input  logic   psel,
	input  logic   penable,
	input  logic   pwrite,
	input  paddr_t paddr,
	input  pdata_t pwdata,
	output pdata_t prdata,
	output logic   pready,
	output logic   pslverr,

	// Pads and side outputs
	input  pad_t   padin,
	output pad_t   padout,
	output pad_t   padoe,
	output logic   pwm_out,     // LCD backlight
	output irq_t   irq_force
);

// ==================================================
// Interconnect
// ==================================================

logic   psel_gpio;
logic   psel_pwm;
logic   psel_tbman;
pdata_t prdata_gpio;
pdata_t prdata_pwm;
pdata_t prdata_tbman;

apb_splitter inst_apb_splitter (
	.clk_sys      (clk_sys),
	.rst          (rst),
	.psel         (psel),
	.penable      (penable),
	.paddr        (paddr),
	.psel_gpio    (psel_gpio),
	.psel_pwm     (psel_pwm),
	.psel_tbman   (psel_tbman),
	.prdata_gpio  (prdata_gpio),
	.prdata_pwm   (prdata_pwm),
	.prdata_tbman (prdata_tbman),
	.prdata       (prdata),
	.pready       (pready),
	.pslverr      (pslverr)
);

// ==================================================
// Slaves
// ==================================================

gpio inst_gpio (
	.clk_sys (clk_sys),
	.rst     (rst),
	.psel    (psel_gpio),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (prdata_gpio),
	.padin   (padin),
	.padout  (padout),
	.padoe   (padoe)
);

pwm_tiny inst_pwm_tiny (
	.clk_sys (clk_sys),
	.rst     (rst),
	.psel    (psel_pwm),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (prdata_pwm),
	.pwm_out (pwm_out)
);

tbman inst_tbman (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.psel      (psel_tbman),
	.penable   (penable),
	.pwrite    (pwrite),
	.paddr     (paddr),
	.pwdata    (pwdata),
	.prdata    (prdata_tbman),
	.irq_force (irq_force)
);

endmodule

`default_nettype wire

/* rtl/periph_pkg.sv */
// ==================================================
// Types shared across the APB peripheral segment.
// Widths follow the settings header.
// ==================================================
`default_nettype none

`include "periph_settings.svh"

package periph_pkg;

typedef logic [`W_PADDR-1:0] paddr_t;  // APB address
typedef logic [`W_DATA-1:0]  pdata_t;  // APB data word
typedef logic [`N_PADS-1:0]  pad_t;    // One bit per pad
typedef logic [`W_PWM-1:0]   pwm_t;    // PWM count, level or divider
typedef logic [`W_IRQ-1:0]   irq_t;    // Interrupt lines

// Phase of an APB transfer
typedef enum logic [1:0] {
	IDLE,
	SETUP,
	ACCESS
} apb_phase_e;

endpackage

`default_nettype wire

/* rtl/periph_settings.svh */
// ==================================================
// Widths, slot map and register offsets of the
// peripheral segment. A slot is picked by paddr[15:12]
// and every slave decodes only paddr[3:2].
// ==================================================
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

`define N_PADS      11
`define W_PADDR     16
`define W_DATA      32
`define W_PWM       8
`define W_IRQ       16

// Values of paddr[15:12]
`define SLOT_GPIO   4'h0
`define SLOT_PWM    4'h1
`define SLOT_TBMAN  4'h2

// Byte offsets within a slot
`define REG_0       4'h0
`define REG_4       4'h4
`define REG_8       4'h8

`endif

/* rtl/pwm_tiny.sv */
// ==================================================
// Small PWM for the LCD backlight. The counter steps
// once every DIV+1 cycles and the output is high
// while count < LEVEL. Disabled, it holds at zero
// and pwm_out follows INVERT one cycle later.
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "periph_settings.svh"

module pwm_tiny import periph_pkg::*; (
	input  logic   clk_sys,
	input  logic   rst,

	input  logic   psel,
	input  logic   penable,
	input  logic   pwrite,
	input  paddr_t paddr,
	input  pdata_t pwdata,
	output pdata_t prdata,

	output logic   pwm_out
);

logic       en_q;      // CTRL bit 0
logic       inv_q;     // CTRL bit 1
pwm_t       div_q;
pwm_t       level_q;
pwm_t       prescale;
pwm_t       count;
logic [3:0] offset;
logic       wen;

assign offset = {paddr[3:2], 2'b00};
assign wen    = psel && penable && pwrite;

// ==================================================
// Control registers
// ==================================================

always_ff @(posedge clk_sys) begin
	if (rst) begin
		en_q    <= 1'b0;
		inv_q   <= 1'b0;
		div_q   <= '0;
		level_q <= '0;
	end else if (wen) begin
		if (offset == `REG_0) begin
			en_q  <= pwdata[0];
			inv_q <= pwdata[1];
		end
		if (offset == `REG_4)
			div_q <= pwdata[`W_PWM-1:0];
		if (offset == `REG_8)
			level_q <= pwdata[`W_PWM-1:0];
	end
end

always_comb begin
	case (offset)
		`REG_0:  prdata = {{(`W_DATA-2){1'b0}}, inv_q, en_q};
		`REG_4:  prdata = pdata_t'(div_q);
		`REG_8:  prdata = pdata_t'(level_q);
		default: prdata = '0;
	endcase
end

// ==================================================
// Prescaler, counter and output
// ==================================================

always_ff @(posedge clk_sys) begin
	if (rst || !en_q) begin
		prescale <= '0;
		count    <= '0;
	end else if (prescale == div_q) begin
		prescale <= '0;
		count    <= count + pwm_t'(1);  // Wraps 255 to 0
	end else begin
		prescale <= prescale + pwm_t'(1);
	end
end

always_ff @(posedge clk_sys) begin
	if (rst)
		pwm_out <= 1'b0;
	else
		pwm_out <= (en_q && count < level_q) ^ inv_q;
end

// Once CTRL has settled, a disabled block shows just INVERT
a_idle_level: assert property (@(posedge clk_sys) disable iff (rst)
	!en_q && $stable({en_q, inv_q}) |-> pwm_out == inv_q);

endmodule

`default_nettype wire

/* rtl/tbman.sv */
// ==================================================
// Testbench manager. SCRATCH at 0x0 holds 32 bits,
// IRQ_FORCE at 0x4 keeps only its low 16 bits.
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "periph_settings.svh"

module tbman import periph_pkg::*; (
	input  logic   clk_sys,
	input  logic   rst,

	input  logic   psel,
	input  logic   penable,
	input  logic   pwrite,
	input  paddr_t paddr,
	input  pdata_t pwdata,
	output pdata_t prdata,

	output irq_t   irq_force
);

pdata_t     scratch_q;
irq_t       irq_q;
logic [3:0] offset;
logic       wen;

assign offset = {paddr[3:2], 2'b00};
assign wen    = psel && penable && pwrite;

always_ff @(posedge clk_sys) begin
	if (rst) begin
		scratch_q <= '0;
		irq_q     <= '0;
	end else if (wen) begin
		if (offset == `REG_0)
			scratch_q <= pwdata;
		if (offset == `REG_4)
			irq_q <= pwdata[`W_IRQ-1:0];  // Upper bits dropped
	end
end

always_comb begin
	case (offset)
		`REG_0:  prdata = scratch_q;
		`REG_4:  prdata = pdata_t'(irq_q);
		default: prdata = '0;
	endcase
end

assign irq_force = irq_q;

a_irq_on_write: assert property (@(posedge clk_sys) disable iff (rst)
	!$stable(irq_force) |-> $past(rst || (wen && offset == `REG_4)));

endmodule

`default_nettype wire

/* test/tb_periph_core.sv */
// ==================================================
// Testbench for the APB peripheral segment. Acts as
// a zero wait state APB master and checks registers
// and pins against a model. DIV is kept to 2 random
// bits so the PWM windows stay short.
// ==================================================
`timescale 1ns/10ps
`default_nettype none

`include "periph_settings.svh"

module tb_periph_core import periph_pkg::*; ();

localparam int CLK_PERIOD   = 100;
localparam int DRIVE_DELAY  = 5;
localparam int PWM_RUNS     = 4;
localparam int MAX_DIV      = 3;
localparam int REG_CYCLES   = 1500;  // Register tests with plenty of room
localparam int LIMIT_CYCLES = 10 + REG_CYCLES + PWM_RUNS * (256 * (MAX_DIV + 1) + 60);

logic   clk_sys;
logic   rst;
logic   psel;
logic   penable;
logic   pwrite;
paddr_t paddr;
pdata_t pwdata;
pdata_t prdata;
logic   pready;
logic   pslverr;
pad_t   padin;
pad_t   padout;
pad_t   padoe;
logic   pwm_out;
irq_t   irq_force;

// Register model
pad_t   out_m;
pad_t   oe_m;
pad_t   in_m;
logic   en_m;
logic   inv_m;
pwm_t   div_m;
pwm_t   level_m;
pdata_t scratch_m;
irq_t   irq_m;

logic [31:0] lfsr_state = 32'hf812d3c8;
int          errors;
int          checks;
int          test_err_base;

periph_core i_periph_core (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.psel      (psel),
	.penable   (penable),
	.pwrite    (pwrite),
	.paddr     (paddr),
	.pwdata    (pwdata),
	.prdata    (prdata),
	.pready    (pready),
	.pslverr   (pslverr),
	.padin     (padin),
	.padout    (padout),
	.padoe     (padoe),
	.pwm_out   (pwm_out),
	.irq_force (irq_force)
);

initial begin
	clk_sys = 1'b0;
	forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
end

// ==================================================
// Random bits, bus driver and checking
// ==================================================

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		r = {r[30:0], lfsr_state[0]};
	end
	return r;
endfunction

function automatic paddr_t reg_addr(input logic [3:0] slot, input logic [3:0] off);
	return {slot, 8'h00, off};
endfunction

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
	end
endtask

// One transfer, setup phase then access phase
task automatic apb_xfer(input logic write, input paddr_t addr, input pdata_t data,
		output pdata_t rdata, output logic err);
	@(posedge clk_sys);
	#DRIVE_DELAY;
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = write;
	paddr   = addr;
	pwdata  = data;
	@(posedge clk_sys);
	#DRIVE_DELAY;
	penable = 1'b1;
	@(negedge clk_sys);
	while (!pready)
		@(negedge clk_sys);  // Access ends on the edge that sees pready
	compare("pready", pready, 1'b1);  // Zero wait states
	rdata = prdata;
	err   = pslverr;
	@(posedge clk_sys);
	#DRIVE_DELAY;
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

task automatic reg_write(input paddr_t addr, input pdata_t data, input logic exp_err);
	pdata_t rdata;
	logic   err;
	apb_xfer(1'b1, addr, data, rdata, err);
	compare($sformatf("pslverr[%h]", addr), err, exp_err);
endtask

task automatic reg_read(input paddr_t addr, input pdata_t exp, input logic exp_err);
	pdata_t rdata;
	logic   err;
	apb_xfer(1'b0, addr, '0, rdata, err);
	compare($sformatf("pslverr[%h]", addr), err, exp_err);
	compare($sformatf("prdata[%h]", addr), rdata, exp);
endtask

// Pins and every mapped register against the model
task automatic check_model;
	@(negedge clk_sys);
	compare("padout", padout, out_m);
	compare("padoe", padoe, oe_m);
	compare("irq_force", irq_force, irq_m);
	if (!en_m)
		compare("pwm_out", pwm_out, inv_m);
	reg_read(reg_addr(`SLOT_GPIO, `REG_0), pdata_t'(out_m), 1'b0);
	reg_read(reg_addr(`SLOT_GPIO, `REG_4), pdata_t'(oe_m), 1'b0);
	reg_read(reg_addr(`SLOT_GPIO, `REG_8), pdata_t'(in_m), 1'b0);
	reg_read(reg_addr(`SLOT_PWM, `REG_0), pdata_t'({inv_m, en_m}), 1'b0);
	reg_read(reg_addr(`SLOT_PWM, `REG_4), pdata_t'(div_m), 1'b0);
	reg_read(reg_addr(`SLOT_PWM, `REG_8), pdata_t'(level_m), 1'b0);
	reg_read(reg_addr(`SLOT_TBMAN, `REG_0), scratch_m, 1'b0);
	reg_read(reg_addr(`SLOT_TBMAN, `REG_4), pdata_t'(irq_m), 1'b0);
endtask

task automatic test_done(input string name);
	$display("test %s finished, %0d mismatches", name, errors - test_err_base);
	test_err_base = errors;
endtask

// ==================================================
// Tests
// ==================================================

task automatic test_gpio;
	pdata_t d;
	for (int i = 0; i < 8; i++) begin
		d = rand_bits(16);  // Upper bits must be dropped
		reg_write(reg_addr(`SLOT_GPIO, `REG_0), d, 1'b0);
		out_m = d[`N_PADS-1:0];
		d = rand_bits(16);
		reg_write(reg_addr(`SLOT_GPIO, `REG_4), d, 1'b0);
		oe_m = d[`N_PADS-1:0];
		@(posedge clk_sys);
		#DRIVE_DELAY;
		in_m  = pad_t'(rand_bits(`N_PADS));
		padin = in_m;
		repeat (3) @(posedge clk_sys);  // Through the synchronizer
		reg_write(reg_addr(`SLOT_GPIO, `REG_8), rand_bits(32), 1'b0);  // Read-only
		check_model;
	end
	test_done("gpio");
endtask

task automatic test_pwm;
	int high;
	int window;
	int expected;
	for (int run = 0; run < PWM_RUNS; run++) begin
		div_m   = pwm_t'(rand_bits(2));
		level_m = pwm_t'(rand_bits(8));
		inv_m   = run[0];
		en_m    = 1'b1;
		reg_write(reg_addr(`SLOT_PWM, `REG_4), pdata_t'(div_m), 1'b0);
		reg_write(reg_addr(`SLOT_PWM, `REG_8), pdata_t'(level_m), 1'b0);
		reg_write(reg_addr(`SLOT_PWM, `REG_0), pdata_t'({inv_m, en_m}), 1'b0);
		window   = 256 * (int'(div_m) + 1);
		expected = int'(level_m) * (int'(div_m) + 1);
		if (inv_m)
			expected = window - expected;
		high = 0;
		@(posedge clk_sys);  // Output register catches up
		repeat (window) begin
			@(negedge clk_sys);
			if (pwm_out)
				high++;
		end
		compare("pwm_out high cycles", high, expected);
		en_m = 1'b0;
		reg_write(reg_addr(`SLOT_PWM, `REG_0), pdata_t'({inv_m, en_m}), 1'b0);
		@(posedge clk_sys);
		repeat (4) begin
			@(negedge clk_sys);
			compare("pwm_out", pwm_out, inv_m);
		end
		check_model;
	end
	test_done("pwm");
endtask

task automatic test_tbman;
	pdata_t d;
	for (int i = 0; i < 8; i++) begin
		scratch_m = rand_bits(32);
		reg_write(reg_addr(`SLOT_TBMAN, `REG_0), scratch_m, 1'b0);
		reg_read(reg_addr(`SLOT_TBMAN, `REG_0), scratch_m, 1'b0);
		d = rand_bits(32);
		reg_write(reg_addr(`SLOT_TBMAN, `REG_4), d, 1'b0);
		irq_m = d[`W_IRQ-1:0];
		compare("irq_force", irq_force, irq_m);
		reg_read(reg_addr(`SLOT_TBMAN, `REG_4), pdata_t'(irq_m), 1'b0);
	end
	test_done("tbman");
endtask

task automatic test_unmapped;
	logic [3:0] slot;
	paddr_t     a;
	paddr_t     unused [4];
	for (int i = 0; i < 8; i++) begin
		slot = 4'd3 + 4'(rand_bits(4) % 13);  // Slots 3 to 15
		a = paddr_t'(rand_bits(12));
		a[15:12] = slot;
		a[1:0]   = 2'b00;
		reg_write(a, rand_bits(32), 1'b1);
		reg_read(a, '0, 1'b1);
	end
	check_model;
	// Holes inside mapped slots
	unused[0] = reg_addr(`SLOT_GPIO, 4'hc);
	unused[1] = reg_addr(`SLOT_PWM, 4'hc);
	unused[2] = reg_addr(`SLOT_TBMAN, `REG_8);
	unused[3] = reg_addr(`SLOT_TBMAN, 4'hc);
	foreach (unused[k]) begin
		reg_write(unused[k], rand_bits(32), 1'b0);
		reg_read(unused[k], '0, 1'b0);
	end
	check_model;
	test_done("unmapped");
endtask

initial begin
	rst       = 1'b1;
	psel      = 1'b0;
	penable   = 1'b0;
	pwrite    = 1'b0;
	paddr     = '0;
	pwdata    = '0;
	padin     = '0;
	out_m     = '0;
	oe_m      = '0;
	in_m      = '0;
	en_m      = 1'b0;
	inv_m     = 1'b0;
	div_m     = '0;
	level_m   = '0;
	scratch_m = '0;
	irq_m     = '0;
	errors        = 0;
	checks        = 0;
	test_err_base = 0;
	repeat (5) @(posedge clk_sys);
	#DRIVE_DELAY;
	rst = 1'b0;
	check_model;
	test_done("reset");
	test_gpio();
	test_pwm();
	test_tbman();
	test_unmapped();
	$display("%0d checks, %0d mismatches", checks, errors);
	if (errors == 0)
		$display("NO ERRORS");
	else
		$display("ERRORS FOUND");
	$finish;
end

// Watchdog
initial begin
	repeat (LIMIT_CYCLES) @(posedge clk_sys);
	$display("Run did not finish within %0d cycles and was stopped", LIMIT_CYCLES);
	$display("ERRORS FOUND");
	$finish;
end

endmodule

`default_nettype wire
